// ==== common/rs_div_pkg.sv ====
`default_nettype none

package rs_div_pkg;

    typedef logic [7:0]  phys_tag_t;
    typedef logic [31:0] pc_t;

    // divider opcodes, funct3 style encoding
    typedef enum logic [3:0] {
        OP_DIV  = 4'h4,
        OP_DIVU = 4'h5,
        OP_REM  = 4'h6,
        OP_REMU = 4'h7
    } div_op_e;

    // index into the broadcast array
    typedef enum logic [2:0] {
        WAKE_ALU = 3'd0,
        WAKE_MUL = 3'd1,
        WAKE_DIV = 3'd2,
        WAKE_MEM = 3'd3,
        WAKE_BR  = 3'd4,
        WAKE_P   = 3'd5,
        WAKE_CSR = 3'd6
    } wake_src_e;

    localparam int NUM_WAKE_SRC = 7;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } wake_bcast_t;

    typedef struct packed {
        pc_t       pc;
        phys_tag_t rd;
        div_op_e   op;
        phys_tag_t src1;
        phys_tag_t src2;
        logic      src1_rdy;
        logic      src2_rdy;
    } alloc_req_t;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        phys_tag_t rd;
        div_op_e   op;
        phys_tag_t src1;
        phys_tag_t src2;
    } issue_t;

    localparam int RS_DEPTH_DEF  = 16;
    localparam int RS_WINDOW_DEF = 8;

endpackage

`default_nettype wire

// ==== rs_div/rs_entry_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_entry_array import rs_div_pkg::*; #(
    parameter int DEPTH = RS_DEPTH_DEF
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic                     alloc_start,
    input  alloc_req_t               alloc_req,
    input  logic                     alloc_src1_hit,
    input  logic                     alloc_src2_hit,
    input  logic [DEPTH-1:0]         src1_hit,
    input  logic [DEPTH-1:0]         src2_hit,
    input  logic                     clear_en,
    input  logic [$clog2(DEPTH)-1:0] clear_idx,
    output logic [DEPTH-1:0]         busy,
    output logic [DEPTH-1:0]         src1_rdy,
    output logic [DEPTH-1:0]         src2_rdy,
    output alloc_req_t               slots [DEPTH],
    output phys_tag_t                stored_src1 [DEPTH],
    output phys_tag_t                stored_src2 [DEPTH],
    output logic [$clog2(DEPTH)-1:0] head
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [IDX_W-1:0] tail;
    logic             alloc_fire;
    logic             head_skip;

    assign alloc_fire = alloc_start && !flush; // flush drops the alloc
    assign head_skip  = !busy[head] && (head != tail);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= '0;
            src1_rdy <= '0;
            src2_rdy <= '0;
            head     <= '0;
            tail     <= '0;
        end else if (flush) begin
            busy     <= '0;
            src1_rdy <= '0;
            src2_rdy <= '0;
            head     <= '0;
            tail     <= '0;
        end else begin
            src1_rdy <= src1_rdy | src1_hit; // wakeup merge
            src2_rdy <= src2_rdy | src2_hit;

            if (clear_en) begin
                busy[clear_idx]     <= 1'b0; // issued this edge
                src1_rdy[clear_idx] <= 1'b0;
                src2_rdy[clear_idx] <= 1'b0;
            end

            // later assignments win over the merge above for the tail slot
            if (alloc_fire) begin
                busy[tail]     <= 1'b1;
                src1_rdy[tail] <= alloc_req.src1_rdy | alloc_src1_hit;
                src2_rdy[tail] <= alloc_req.src2_rdy | alloc_src2_hit;
                tail           <= tail + 1'b1; // power-of-two wrap
            end

            if (head_skip) begin
                head <= head + 1'b1; // one freed slot per cycle
            end
        end
    end

    // payload store
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            slots[tail] <= alloc_req;
        end
    end

    for (genvar i = 0; i < DEPTH; i++) begin : g_src
        assign stored_src1[i] = slots[i].src1;
        assign stored_src2[i] = slots[i].src2;
    end

endmodule

`default_nettype wire

// ==== rs_div/rs_wakeup.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_wakeup import rs_div_pkg::*; #(
    parameter int DEPTH = RS_DEPTH_DEF
) (
    input  wake_bcast_t      wake [NUM_WAKE_SRC],
    input  phys_tag_t        stored_src1 [DEPTH],
    input  phys_tag_t        stored_src2 [DEPTH],
    input  phys_tag_t        alloc_src1,
    input  phys_tag_t        alloc_src2,
    output logic [DEPTH-1:0] src1_hit,
    output logic [DEPTH-1:0] src2_hit,
    output logic             alloc_src1_hit,
    output logic             alloc_src2_hit
);

    // true when any valid broadcast carries this tag
    function automatic logic tag_hit(input phys_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < NUM_WAKE_SRC; s++) begin
            if (wake[s].valid && (wake[s].tag == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // stored sources ignore the ready state
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            src1_hit[i] = tag_hit(stored_src1[i]);
            src2_hit[i] = tag_hit(stored_src2[i]);
        end
    end

    // same-cycle bypass for the incoming request
    always_comb begin
        alloc_src1_hit = tag_hit(alloc_src1);
        alloc_src2_hit = tag_hit(alloc_src2);
    end

endmodule

`default_nettype wire

// ==== rs_div/rs_issue_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_issue_select import rs_div_pkg::*; #(
    parameter int DEPTH  = RS_DEPTH_DEF,
    parameter int WINDOW = RS_WINDOW_DEF
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic [DEPTH-1:0]         busy,
    input  logic [DEPTH-1:0]         src1_rdy,
    input  logic [DEPTH-1:0]         src2_rdy,
    input  alloc_req_t               slots [DEPTH],
    input  logic [$clog2(DEPTH)-1:0] head,
    output logic                     clear_en,
    output logic [$clog2(DEPTH)-1:0] clear_idx,
    output issue_t                   issue
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0] cand;
    logic             found;
    logic [IDX_W-1:0] pick_idx;
    logic             issue_vld;
    alloc_req_t       pick_q;

    assign cand = busy & src1_rdy & src2_rdy;

    // oldest candidate wins, search starts at head
    always_comb begin
        logic [IDX_W-1:0] idx;
        found    = 1'b0;
        pick_idx = head;
        for (int w = 0; w < WINDOW; w++) begin
            idx = head + IDX_W'(w); // wraps around the ring
            if (!found && cand[idx]) begin
                found    = 1'b1;
                pick_idx = idx;
            end
        end
    end

    assign clear_en  = found; // freed on the same edge it registers
    assign clear_idx = pick_idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_vld <= 1'b0;
        end else if (flush) begin
            issue_vld <= 1'b0;
        end else begin
            issue_vld <= found;
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            pick_q <= slots[pick_idx];
        end
    end

    assign issue = '{
        valid: issue_vld,
        pc:    pick_q.pc,
        rd:    pick_q.rd,
        op:    pick_q.op,
        src1:  pick_q.src1,
        src2:  pick_q.src2
    };

endmodule

`default_nettype wire

// ==== verilog/rs_div_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_div_top import rs_div_pkg::*; #(
    parameter int DEPTH  = RS_DEPTH_DEF,  // power of two
    parameter int WINDOW = RS_WINDOW_DEF  // at most DEPTH
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  logic        alloc_start,
    input  alloc_req_t  alloc_req,
    input  wake_bcast_t wake [NUM_WAKE_SRC],
    output issue_t      issue
);

    logic [DEPTH-1:0]         src1_hit;
    logic [DEPTH-1:0]         src2_hit;
    logic                     alloc_src1_hit;
    logic                     alloc_src2_hit;
    logic [DEPTH-1:0]         busy;
    logic [DEPTH-1:0]         src1_rdy;
    logic [DEPTH-1:0]         src2_rdy;
    alloc_req_t               slots [DEPTH];
    phys_tag_t                stored_src1 [DEPTH];
    phys_tag_t                stored_src2 [DEPTH];
    logic [$clog2(DEPTH)-1:0] head;
    logic                     clear_en;
    logic [$clog2(DEPTH)-1:0] clear_idx;

    rs_entry_array #(.DEPTH(DEPTH)) u_entry_array (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .alloc_start(alloc_start), .alloc_req(alloc_req),
        .alloc_src1_hit(alloc_src1_hit), .alloc_src2_hit(alloc_src2_hit),
        .src1_hit(src1_hit), .src2_hit(src2_hit),
        .clear_en(clear_en), .clear_idx(clear_idx),
        .busy(busy), .src1_rdy(src1_rdy), .src2_rdy(src2_rdy),
        .slots(slots), .stored_src1(stored_src1), .stored_src2(stored_src2),
        .head(head)
    );

    rs_wakeup #(.DEPTH(DEPTH)) u_wakeup (
        .wake(wake),
        .stored_src1(stored_src1), .stored_src2(stored_src2),
        .alloc_src1(alloc_req.src1), .alloc_src2(alloc_req.src2),
        .src1_hit(src1_hit), .src2_hit(src2_hit),
        .alloc_src1_hit(alloc_src1_hit), .alloc_src2_hit(alloc_src2_hit)
    );

    rs_issue_select #(.DEPTH(DEPTH), .WINDOW(WINDOW)) u_issue_select (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .busy(busy), .src1_rdy(src1_rdy), .src2_rdy(src2_rdy),
        .slots(slots), .head(head),
        .clear_en(clear_en), .clear_idx(clear_idx),
        .issue(issue)
    );

endmodule

`default_nettype wire

// ==== verif/tb_rs_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rs_div import rs_div_pkg::*; ();

    localparam int DEPTH    = 16;
    localparam int WINDOW   = 8;
    localparam int MAX_WAIT = 200; // cycles per drain

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic        alloc_start;
    alloc_req_t  alloc_req;
    wake_bcast_t wake [NUM_WAKE_SRC];
    issue_t      issue;

    issue_t exp_q [$]; // expected issue order
    integer seed;
    int     err_cnt;
    int     check_cnt;
    int     test_cnt;
    int     test_fail_cnt;
    int     cur_test;
    int     test_err_base;
    logic   quiet;     // any issue now is an error

    rs_div_top #(.DEPTH(DEPTH), .WINDOW(WINDOW)) dut0 (
        .clk(clk), .arst_n(arst_n), .flush(flush), .alloc_start(alloc_start),
        .alloc_req(alloc_req), .wake(wake), .issue(issue)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic idle_inputs();
        flush       = 1'b0;
        alloc_start = 1'b0;
        alloc_req   = '0;
        for (int s = 0; s < NUM_WAKE_SRC; s++) begin
            wake[s] = '0;
        end
    endtask

    // one cycle with the current drive, then back to idle
    task automatic next_cycle();
        @(posedge clk);
        #2;
        idle_inputs();
    endtask

    task automatic set_alloc(input logic [31:0] pc, rd, op, s1, s2, r1, r2);
        alloc_start        = 1'b1;
        alloc_req.pc       = pc;
        alloc_req.rd       = rd[7:0];
        alloc_req.op       = div_op_e'(op[3:0]);
        alloc_req.src1     = s1[7:0];
        alloc_req.src2     = s2[7:0];
        alloc_req.src1_rdy = r1[0];
        alloc_req.src2_rdy = r2[0];
    endtask

    task automatic set_wake(input logic [31:0] src, tag);
        wake[src[2:0]].valid = 1'b1;
        wake[src[2:0]].tag   = tag[7:0];
    endtask

    task automatic push_expected(input logic [31:0] rd, op, pc, s1, s2);
        issue_t e;
        e.valid = 1'b1;
        e.pc    = pc;
        e.rd    = rd[7:0];
        e.op    = div_op_e'(op[3:0]);
        e.src1  = s1[7:0];
        e.src2  = s2[7:0];
        exp_q.push_back(e);
    endtask

    // both sources ready, so these issue in allocation order
    task automatic alloc_random(input int count);
        logic [31:0] pc;
        logic [31:0] rd;
        logic [31:0] op;
        logic [31:0] s1;
        logic [31:0] s2;
        for (int k = 0; k < count; k++) begin
            pc = $random(seed);
            rd = $random(seed);
            op = 32'h4 + ($random(seed) & 32'h3);
            s1 = $random(seed);
            s2 = $random(seed);
            set_alloc(pc, rd, op, s1, s2, 32'h1, 32'h1);
            push_expected(rd, op, pc, s1, s2);
            next_cycle();
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got, want);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("[FAIL] %0t: test %0d field %s is %h, expected %h",
                     $time, cur_test, what, got, want);
        end
    endtask

    task automatic compare_issue(input issue_t got);
        issue_t want;
        if (quiet) begin
            err_cnt++;
            $display("test %0d: pc %h issued while every entry should still wait",
                     cur_test, got.pc);
        end else if (exp_q.size() == 0) begin
            err_cnt++;
            $display("test %0d: unexpected issue of pc %h", cur_test, got.pc);
        end else begin
            want = exp_q.pop_front();
            check_value("rd", 32'(got.rd), 32'(want.rd));
            check_value("op", 32'(got.op), 32'(want.op));
            check_value("pc", got.pc, want.pc);
            check_value("src1", 32'(got.src1), 32'(want.src1));
            check_value("src2", 32'(got.src2), 32'(want.src2));
        end
    endtask

    // issue is registered, so the falling edge sees it settled
    always @(negedge clk) begin
        if (arst_n && issue.valid) begin
            compare_issue(issue);
        end
    end

    task automatic wait_drained(output logic stalled);
        int cycles;
        cycles  = 0;
        stalled = 1'b0;
        while (exp_q.size() != 0 && !stalled) begin
            next_cycle();
            cycles++;
            if (cycles >= MAX_WAIT && exp_q.size() != 0) begin
                stalled = 1'b1;
                err_cnt++;
                $display("test %0d stalled: %0d expected issues missing after %0d cycles",
                         cur_test, exp_q.size(), MAX_WAIT);
            end
        end
    endtask

    task automatic report_test();
        test_cnt++;
        if (err_cnt == test_err_base) begin
            $display("test %0d: ok", cur_test);
        end else begin
            test_fail_cnt++;
            $display("test %0d: failed", cur_test);
        end
    endtask

    initial begin
        string       line;
        string       args;
        byte         cmd;
        int          fd;
        int          n;
        logic        stop_run;
        logic [31:0] v [9];
        seed          = 37625;
        err_cnt       = 0;
        check_cnt     = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        cur_test      = 0;
        test_err_base = 0;
        quiet         = 1'b0;
        stop_run      = 1'b0;
        idle_inputs();
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        fd = $fopen("verif/rs_div_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/rs_div_cases.txt");
            err_cnt++;
            stop_run = 1'b1;
        end
        while (!stop_run && $fgets(line, fd) > 0) begin
            cmd  = line[0];
            args = line.substr(1, line.len() - 1);
            n    = 0;
            case (cmd)
                "T": begin
                    void'($sscanf(args, "%d", n));
                    cur_test      = n;
                    test_err_base = err_cnt;
                end
                "R": begin
                    void'($sscanf(args, "%d", n));
                    alloc_random(n);
                end
                "A", "X": begin
                    void'($sscanf(args, "%h %h %h %h %h %h %h %h %h",
                                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]));
                    set_alloc(v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                    if (cmd == "X") begin
                        set_wake(v[7], v[8]); // same-cycle broadcast
                    end
                    next_cycle();
                end
                "W": begin
                    void'($sscanf(args, "%h %h", v[0], v[1]));
                    set_wake(v[0], v[1]);
                    next_cycle();
                end
                "F": begin
                    flush = 1'b1;
                    next_cycle();
                end
                "I": begin
                    void'($sscanf(args, "%d", n));
                    repeat (n) next_cycle();
                end
                "N": begin
                    void'($sscanf(args, "%d", n));
                    quiet = 1'b1;
                    repeat (n) next_cycle();
                    quiet = 1'b0;
                end
                "E": begin
                    void'($sscanf(args, "%h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]));
                    push_expected(v[0], v[1], v[2], v[3], v[4]);
                end
                "D": begin
                    wait_drained(stop_run);
                    report_test();
                end
                default: ; // comments and blank lines
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!stop_run) begin
            repeat (10) next_cycle(); // catch stray issues
        end

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0 && test_cnt > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/rs_div_cases.txt ====
# steps: T test, R n random ready allocs, A pc rd op src1 src2 rdy1 rdy2, X as A plus src tag,
#   W src tag, F flush, I n idle, N n cycles with no issue allowed, D wait for expected issues
# expected issue: E rd op pc src1 src2 (hex); src 0 alu 1 mul 2 div 3 mem 4 br 5 p 6 csr
T 1
R 6
D
T 2
E 22 5 00000204 13 14
E 23 6 00000208 15 16
E 24 7 0000020c 17 18
E 21 4 00000200 11 12
A 00000200 21 4 11 12 0 1
A 00000204 22 5 13 14 1 1
A 00000208 23 6 15 16 1 1
A 0000020c 24 7 17 18 1 1
I 6
W 0 11
D
T 3
E 66 6 00003018 36 00
E 65 5 00003014 35 00
E 64 4 00003010 34 00
E 63 7 0000300c 33 00
E 62 6 00003008 32 00
E 61 5 00003004 31 00
E 60 4 00003000 30 00
A 00003000 60 4 30 00 0 1
A 00003004 61 5 31 00 0 1
A 00003008 62 6 32 00 0 1
A 0000300c 63 7 33 00 0 1
A 00003010 64 4 34 00 0 1
A 00003014 65 5 35 00 0 1
A 00003018 66 6 36 00 0 1
N 50
W 6 36
W 5 35
W 4 34
W 3 33
W 2 32
W 1 31
W 0 30
D
T 4
E 70 6 00004000 40 00
E 71 7 00004004 01 41
X 00004000 70 6 40 00 0 1 3 40
X 00004004 71 7 01 41 1 0 5 41
D
T 5
E 80 5 00006000 02 03
A 00005000 7a 4 50 00 0 1
A 00005004 7b 5 51 00 0 1
A 00005008 7c 6 04 05 1 1
F
N 20
W 0 50
W 1 51
N 10
A 00006000 80 5 02 03 1 1
D

// ==== rs_div.f ====
common/rs_div_pkg.sv
rs_div/rs_entry_array.sv
rs_div/rs_wakeup.sv
rs_div/rs_issue_select.sv
verilog/rs_div_top.sv
verif/tb_rs_div.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_rs_div
FILELIST  := rs_div.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
